//--- axi_dma_rd.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module axi_dma_rd import stripe_dma_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  // Stripe request from the dispatcher
  input  logic      ctrl_valid,
  output logic      stat_ready,
  input  dma_addr_t ctrl_addr,
  input  dma_len_t  ctrl_len,
  // AXI4 read address
  output logic      arvalid,
  input  logic      arready,
  output dma_addr_t araddr,
  output logic [7:0] arlen,
  // AXI4 read data
  input  logic      rvalid,
  output logic      rready,
  input  dma_data_t rdata,
  input  logic      rlast,
  // Beat stream towards the merger
  output logic      axis_tvalid,
  input  logic      axis_tready,
  output dma_data_t axis_tdata,
  output logic      axis_tlast
);

  localparam int BEAT_BYTES  = `DMA_DATA_BITS / 8;
  localparam int LOG_DATA    = $clog2(BEAT_BYTES);
  localparam int LOG_BURST   = $clog2(`DMA_BURST_LEN);
  localparam int BURST_BYTES = `DMA_BURST_LEN * BEAT_BYTES;
  // Wide enough for the burst count of any stripe
  localparam int CNT_W       = `DMA_LEN_BITS - LOG_BURST - LOG_DATA;

  logic [CNT_W-1:0]     num_full;
  logic [LOG_BURST-1:0] part_beats;
  logic                 has_part;
  logic                 take;
  logic                 start_r;
  logic [CNT_W-1:0]     bursts_m1;
  logic [7:0]           final_len;
  logic [CNT_W-1:0]     ar_cnt;
  logic                 ar_final;
  logic                 ar_idle;
  logic                 ar_done;
  logic                 arvalid_r;
  dma_addr_t            addr_r;
  logic                 arxfer;
  logic                 rxfer;
  logic                 q_not_full;
  logic                 r_final;

  //////////////////////////////////////////////////////////////////////
  // Stripe split
  //////////////////////////////////////////////////////////////////////

  // Full bursts and leftover beats, length assumed beat aligned
  assign num_full   = ctrl_len[LOG_DATA+LOG_BURST +: CNT_W];
  assign part_beats = ctrl_len[LOG_DATA +: LOG_BURST];
  assign has_part   = |part_beats;

  assign stat_ready = ar_idle;
  assign take       = ctrl_valid & stat_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      start_r <= 1'b0;
    end else begin
      start_r <= take;
    end
  end

  // Burst count minus one, final burst length as AXI arlen
  always_ff @(posedge aclk) begin
    if (take) begin
      bursts_m1 <= has_part ? num_full : num_full - 1'b1;
      final_len <= has_part ? 8'(part_beats) - 8'd1 : 8'(`DMA_BURST_LEN - 1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AR channel
  //////////////////////////////////////////////////////////////////////

  assign arxfer  = arvalid_r & arready;
  assign ar_done = arxfer & ar_final;

  assign arvalid = arvalid_r;
  assign araddr  = addr_r;
  assign arlen   = ar_final ? final_len : 8'(`DMA_BURST_LEN - 1);

  // Bursts left after the current one, loaded a cycle after the start
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_cnt <= '0;
    end else if (start_r) begin
      ar_cnt <= bursts_m1;
    end else if (arxfer) begin
      ar_cnt <= ar_cnt - 1'b1;
    end
  end
  assign ar_final = (ar_cnt == '0);

  // Idle from the last AR handshake until the next start
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_idle <= 1'b1;
    end else if (take) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // New AR only while the burst queue has room
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arvalid_r <= 1'b0;
    end else if (!ar_idle && !arvalid_r && q_not_full) begin
      arvalid_r <= 1'b1;
    end else if (arready) begin
      arvalid_r <= 1'b0;
    end
  end

  // Step one full burst per handshake
  always_ff @(posedge aclk) begin
    if (take) begin
      addr_r <= ctrl_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + dma_addr_t'(BURST_BYTES);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // R channel to stream
  //////////////////////////////////////////////////////////////////////

  assign rready      = axis_tready;
  assign rxfer       = rvalid & rready;
  assign axis_tvalid = rvalid;
  assign axis_tdata  = rdata;
  // Only the last beat of the final burst closes the stripe
  assign axis_tlast  = rlast & r_final;

  // One final-burst flag per outstanding burst, popped on rlast
  burst_queue burst_q_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (arxfer),
    .push_data (ar_final),
    .pop       (rxfer & rlast),
    .not_full  (q_not_full),
    .pop_data  (r_final)
  );

endmodule

//--- burst_queue.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module burst_queue (
  input  logic aclk,
  input  logic aresetn,
  input  logic push,
  input  logic push_data,
  input  logic pop,
  output logic not_full,
  output logic pop_data
);

  localparam int DEPTH = `DMA_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // One flag per burst in flight, oldest at rd_ptr
  logic [DEPTH-1:0] flags;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Flag storage, no reset
  always_ff @(posedge aclk) begin
    if (push) begin
      flags[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, works for non power of two depths too
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Push and pop together leave occupancy unchanged
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  assign not_full = (count != CNT_W'(DEPTH));
  assign pop_data = flags[rd_ptr];

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_stripe_dma \
  -o sim_stripe_dma || exit 1
out=$(./obj_dir/sim_stripe_dma)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

//--- src.f
+incdir+.
stripe_dma_pkg.sv
burst_queue.sv
axi_dma_rd.sv
stripe_dispatch.sv
stripe_merge.sv
stripe_dma_top.sv
tb_mem_model.sv
tb_stripe_dma.sv

//--- stripe_dispatch.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module stripe_dispatch import stripe_dma_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  // Request strobe from outside
  input  logic      req_valid,
  input  dma_addr_t req_addr,
  input  dma_len_t  req_len,
  // End of run from the merger
  input  logic      done,
  output logic      req_err,
  output logic      busy,
  // Broadcast to every engine and the merger
  output logic      start,
  output dma_addr_t ctrl_addr,
  output dma_len_t  ctrl_len
);

  localparam int LOG_N      = $clog2(`STRIPE_N);
  localparam int BEAT_BYTES = `DMA_DATA_BITS / 8;
  // A request must cover a whole number of beats in every bank
  localparam int GRAN_BYTES = `STRIPE_N * BEAT_BYTES;

  logic len_zero;
  logic len_misalign;
  logic accept;

  //////////////////////////////////////////////////////////////////////
  // Request check
  //////////////////////////////////////////////////////////////////////

  assign len_zero     = (req_len == '0);
  assign len_misalign = ((req_len & dma_len_t'(GRAN_BYTES - 1)) != '0);
  // Each stripe is req_len / STRIPE_N, so any dma_len_t request
  // already fits the engine burst counter
  assign accept       = req_valid & ~busy & ~len_zero & ~len_misalign;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      req_err <= 1'b0;
      start   <= 1'b0;
      busy    <= 1'b0;
    end else begin
      req_err <= req_valid & ~accept;
      start   <= accept;
      // Held from acceptance until the final output beat
      if (accept) busy <= 1'b1;
      else if (done) busy <= 1'b0;
    end
  end

  // Same local address in every bank, length split evenly
  always_ff @(posedge aclk) begin
    if (accept) begin
      ctrl_addr <= req_addr;
      ctrl_len  <= req_len >> LOG_N;
    end
  end

endmodule

//--- stripe_dma_cfg.svh
`ifndef STRIPE_DMA_CFG_SVH
`define STRIPE_DMA_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Striping geometry
//////////////////////////////////////////////////////////////////////

// Banks, one read engine per bank
// Keep this a power of two, the dispatcher divides by shifting
`define STRIPE_N 4

//////////////////////////////////////////////////////////////////////
// AXI side
//////////////////////////////////////////////////////////////////////

`define DMA_DATA_BITS 64
`define DMA_ADDR_BITS 32
// Byte length of a whole request
`define DMA_LEN_BITS 20

// Beats in a full INCR burst
`define DMA_BURST_LEN 8
// Burst queue depth, bounds bursts in flight per engine
`define DMA_OUTSTANDING 4

`endif

//--- stripe_dma_pkg.sv
package stripe_dma_pkg;

`include "stripe_dma_cfg.svh"

  //////////////////////////////////////////////////////////////////////
  // Shared types
  //////////////////////////////////////////////////////////////////////

  // Byte address, local to one bank
  typedef logic [`DMA_ADDR_BITS-1:0] dma_addr_t;

  // Length in bytes, whole request or one stripe
  typedef logic [`DMA_LEN_BITS-1:0] dma_len_t;

  // One data beat on AXI and on the stream
  typedef logic [`DMA_DATA_BITS-1:0] dma_data_t;

endpackage

//--- stripe_dma_top.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module stripe_dma_top import stripe_dma_pkg::*; (
  input  logic                         aclk,
  input  logic                         aresetn,
  // Request and status
  input  logic                         req_valid,
  input  dma_addr_t                    req_addr,
  input  dma_len_t                     req_len,
  output logic                         req_err,
  output logic                         busy,
  output logic                         done,
  // One AXI4 read port per bank
  output logic [`STRIPE_N-1:0]         arvalid,
  input  logic [`STRIPE_N-1:0]         arready,
  output dma_addr_t [`STRIPE_N-1:0]    araddr,
  output logic [`STRIPE_N-1:0][7:0]    arlen,
  input  logic [`STRIPE_N-1:0]         rvalid,
  output logic [`STRIPE_N-1:0]         rready,
  input  dma_data_t [`STRIPE_N-1:0]    rdata,
  input  logic [`STRIPE_N-1:0]         rlast,
  // Merged AXI4-Stream output
  output logic                         m_axis_tvalid,
  input  logic                         m_axis_tready,
  output dma_data_t                    m_axis_tdata,
  output logic                         m_axis_tlast
);

  logic                      start;
  dma_addr_t                 ctrl_addr;
  dma_len_t                  ctrl_len;
  logic [`STRIPE_N-1:0]      eng_tvalid;
  logic [`STRIPE_N-1:0]      eng_tready;
  dma_data_t [`STRIPE_N-1:0] eng_tdata;
  logic [`STRIPE_N-1:0]      eng_tlast;

  stripe_dispatch dispatch_i (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(req_valid), .req_addr(req_addr), .req_len(req_len),
    .done(done), .req_err(req_err), .busy(busy),
    .start(start), .ctrl_addr(ctrl_addr), .ctrl_len(ctrl_len)
  );

  // Engines are all idle when start arrives, so ready is not checked
  for (genvar b = 0; b < `STRIPE_N; b++) begin : g_bank
    axi_dma_rd eng_i (
      .aclk(aclk), .aresetn(aresetn),
      .ctrl_valid(start), .stat_ready(), .ctrl_addr(ctrl_addr), .ctrl_len(ctrl_len),
      .arvalid(arvalid[b]), .arready(arready[b]), .araddr(araddr[b]), .arlen(arlen[b]),
      .rvalid(rvalid[b]), .rready(rready[b]), .rdata(rdata[b]), .rlast(rlast[b]),
      .axis_tvalid(eng_tvalid[b]), .axis_tready(eng_tready[b]),
      .axis_tdata(eng_tdata[b]), .axis_tlast(eng_tlast[b])
    );
  end

  stripe_merge merge_i (
    .aclk(aclk), .aresetn(aresetn), .start(start),
    .s_tvalid(eng_tvalid), .s_tready(eng_tready),
    .s_tdata(eng_tdata), .s_tlast(eng_tlast),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast),
    .done(done)
  );

endmodule

//--- stripe_merge.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module stripe_merge import stripe_dma_pkg::*; (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       start,
  // Per-bank engine streams
  input  logic [`STRIPE_N-1:0]       s_tvalid,
  output logic [`STRIPE_N-1:0]       s_tready,
  input  dma_data_t [`STRIPE_N-1:0]  s_tdata,
  input  logic [`STRIPE_N-1:0]       s_tlast,
  // Merged output
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output dma_data_t                  m_axis_tdata,
  output logic                       m_axis_tlast,
  output logic                       done
);

  localparam int SEL_W = (`STRIPE_N > 1) ? $clog2(`STRIPE_N) : 1;
  localparam logic [SEL_W-1:0] LAST = SEL_W'(`STRIPE_N - 1);

  logic [SEL_W-1:0] sel;
  logic             active;
  logic             at_last;
  logic             out_xfer;

  //////////////////////////////////////////////////////////////////////
  // Bank select
  //////////////////////////////////////////////////////////////////////

  // Walk the banks in order, one whole stripe each
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sel    <= '0;
      active <= 1'b0;
    end else if (start) begin
      sel    <= '0;
      active <= 1'b1;
    end else if (out_xfer && s_tlast[sel]) begin
      if (at_last) active <= 1'b0;
      else sel <= sel + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stream mux
  //////////////////////////////////////////////////////////////////////

  assign at_last       = (sel == LAST);
  assign m_axis_tvalid = active & s_tvalid[sel];
  assign m_axis_tdata  = s_tdata[sel];
  // Engine tlast ends a stripe, only the last bank ends the run
  assign m_axis_tlast  = at_last & s_tlast[sel];
  assign out_xfer      = m_axis_tvalid & m_axis_tready;
  assign done          = out_xfer & m_axis_tlast;

  // Other banks see no ready and hold their memory
  always_comb begin
    s_tready      = '0;
    s_tready[sel] = active & m_axis_tready;
  end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module tb_mem_model import stripe_dma_pkg::*; #(
  parameter int BANK      = 0,
  // Percent of cycles with arready or rvalid held low
  parameter int STALL_PCT = 30
) (
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       arvalid,
  output logic       arready,
  input  dma_addr_t  araddr,
  input  logic [7:0] arlen,
  output logic       rvalid,
  input  logic       rready,
  output dma_data_t  rdata,
  output logic       rlast
);

  localparam int BEAT_BYTES = `DMA_DATA_BITS / 8;

  // Accepted bursts waiting for their R beats, oldest first
  dma_addr_t  addr_q[$];
  logic [7:0] len_q[$];
  logic       in_reset;
  logic       ar_hs;
  logic       r_hs;
  dma_addr_t  ar_addr_s;
  logic [7:0] ar_len_s;
  // Burst on the R channel now
  logic       cur_act;
  dma_addr_t  cur_addr;
  logic [7:0] cur_left;

  initial begin
    arready  = 1'b0;
    rvalid   = 1'b0;
    rdata    = '0;
    rlast    = 1'b0;
    cur_act  = 1'b0;
    cur_addr = '0;
    cur_left = '0;
    forever begin
      // Handshakes are settled by the falling edge
      @(negedge aclk);
      in_reset  = !aresetn;
      ar_hs     = arvalid & arready;
      r_hs      = rvalid & rready;
      ar_addr_s = araddr;
      ar_len_s  = arlen;
      @(posedge aclk);
      #2;
      if (in_reset) begin
        addr_q.delete();
        len_q.delete();
        cur_act = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
      end else begin
        if (ar_hs) begin
          addr_q.push_back(ar_addr_s);
          len_q.push_back(ar_len_s);
        end
        if (r_hs && rlast) begin
          cur_act = 1'b0;
        end else if (r_hs) begin
          cur_addr = cur_addr + dma_addr_t'(BEAT_BYTES);
          cur_left = cur_left - 8'd1;
        end
        if (!cur_act && addr_q.size() != 0) begin
          cur_act  = 1'b1;
          cur_addr = addr_q.pop_front();
          cur_left = len_q.pop_front();
        end
        arready = ($urandom_range(99) >= STALL_PCT);
        // A raised rvalid holds until taken
        if (!(rvalid && !r_hs)) rvalid = cur_act && ($urandom_range(99) >= STALL_PCT);
        // Bank index in the top byte, local address below
        rdata = {8'(BANK), 56'(cur_addr)};
        rlast = (cur_left == 8'd0);
      end
    end
  end

endmodule

//--- tb_stripe_dma.sv
`timescale 1ns/1ps
`include "stripe_dma_cfg.svh"

module tb_stripe_dma import stripe_dma_pkg::*; ();

  localparam int N          = `STRIPE_N;
  localparam int BEAT_BYTES = `DMA_DATA_BITS / 8;
  localparam int BURST      = `DMA_BURST_LEN;
  // Request lengths in bytes
  localparam int LEN_MIN    = N * BEAT_BYTES;
  localparam int LEN_SPLIT  = N * (2 * BURST + 3) * BEAT_BYTES;
  localparam int LEN_LONG   = N * 45 * BEAT_BYTES;
  localparam int LEN_BUSY   = N * 16 * BEAT_BYTES;
  localparam int LEN_AFTER  = N * 2 * BEAT_BYTES;
  localparam int ALL_BEATS  = (LEN_MIN + LEN_SPLIT + LEN_LONG + LEN_BUSY + LEN_AFTER)
                              / BEAT_BYTES;
  // Slack per beat for stalls, plus fixed overhead
  localparam int LIMIT_CYCLES = 2000 + 16 * ALL_BEATS;

  logic                      aclk;
  logic                      aresetn;
  logic                      req_valid;
  dma_addr_t                 req_addr;
  dma_len_t                  req_len;
  logic                      req_err;
  logic                      busy;
  logic                      done;
  logic [N-1:0]              arvalid;
  logic [N-1:0]              arready;
  dma_addr_t [N-1:0]         araddr;
  logic [N-1:0][7:0]         arlen;
  logic [N-1:0]              rvalid;
  logic [N-1:0]              rready;
  dma_data_t [N-1:0]         rdata;
  logic [N-1:0]              rlast;
  logic                      m_axis_tvalid;
  logic                      m_axis_tready;
  dma_data_t                 m_axis_tdata;
  logic                      m_axis_tlast;
  logic                      rand_ready;

  // Captured output beats with done per beat, AR log as {bank, arlen, araddr}
  dma_data_t   out_data[$];
  logic        out_last[$];
  logic        out_done[$];
  logic [47:0] ar_log[$];
  // R handshakes over all banks
  int          r_xfers;
  int          done_cnt;
  int          err_cnt;
  int          mismatches;
  int          failures;

  stripe_dma_top dut_i (.*);

  for (genvar b = 0; b < N; b++) begin : g_mem
    tb_mem_model #(.BANK(b)) mem_i (
      .aclk(aclk), .aresetn(aresetn),
      .arvalid(arvalid[b]), .arready(arready[b]), .araddr(araddr[b]), .arlen(arlen[b]),
      .rvalid(rvalid[b]), .rready(rready[b]), .rdata(rdata[b]), .rlast(rlast[b])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Clock, watchdog, output back-pressure
  //////////////////////////////////////////////////////////////////////

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  initial begin
    #(LIMIT_CYCLES * 40);
    $display("Watchdog expired after %0d cycles, a run never finished", LIMIT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    m_axis_tready = 1'b1;
    forever begin
      @(posedge aclk);
      #2;
      m_axis_tready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and monitor
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    mismatches++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // Sampled on the falling edge, away from both drive points
  always @(negedge aclk) begin
    if (aresetn) begin
      if (m_axis_tvalid && m_axis_tready) begin
        out_data.push_back(m_axis_tdata);
        out_last.push_back(m_axis_tlast);
        out_done.push_back(done);
      end else if (done) begin
        report_failure("done strobed without an output transfer");
      end
      if (done) done_cnt++;
      if (req_err) err_cnt++;
      for (int b = 0; b < N; b++) begin
        if (arvalid[b] && arready[b]) ar_log.push_back({8'(b), arlen[b], araddr[b]});
        if (rvalid[b] && rready[b]) r_xfers++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////////////////////////

  function automatic dma_data_t expect_word(input int bank, input dma_addr_t a);
    return {8'(bank), 56'(a)};
  endfunction

  task automatic clear_capture();
    out_data.delete();
    out_last.delete();
    out_done.delete();
    ar_log.delete();
    r_xfers = 0;
  endtask

  // One-cycle request strobe
  task automatic issue_request(input dma_addr_t addr, input int len);
    @(posedge aclk);
    #2;
    req_valid = 1'b1;
    req_addr  = addr;
    req_len   = dma_len_t'(len);
    @(posedge aclk);
    #2;
    req_valid = 1'b0;
  endtask

  // Bounded by the watchdog
  task automatic wait_done(input int n0);
    while (done_cnt == n0) @(posedge aclk);
  endtask

  // Bank 0's stripe first, then bank 1 and on, tlast and done only at the very end
  task automatic check_stream(input dma_addr_t addr, input int len);
    int beats;
    int idx;
    beats = len / (N * BEAT_BYTES);
    if (out_data.size() != beats * N) report_mismatch("beat_count", out_data.size(), beats * N);
    // Each beat leaves its bank exactly once
    if (r_xfers != beats * N) report_mismatch("r_xfers", r_xfers, beats * N);
    for (int b = 0; b < N; b++) begin
      for (int i = 0; i < beats; i++) begin
        idx = b * beats + i;
        if (idx < out_data.size()) begin
          if (out_data[idx] !== expect_word(b, addr + 32'(i * BEAT_BYTES)))
            report_mismatch("m_axis_tdata", out_data[idx],
                            expect_word(b, addr + 32'(i * BEAT_BYTES)));
          if (out_last[idx] !== (idx == beats * N - 1))
            report_mismatch("m_axis_tlast", out_last[idx], idx == beats * N - 1);
          if (out_done[idx] !== (idx == beats * N - 1))
            report_mismatch("done", out_done[idx], idx == beats * N - 1);
        end
      end
    end
  endtask

  // Full bursts first, remainder last, address steps one burst each
  task automatic check_bursts(input dma_addr_t addr, input int len);
    int beats;
    int k;
    logic [7:0] exp_len;
    beats = len / (N * BEAT_BYTES);
    for (int b = 0; b < N; b++) begin
      k = 0;
      foreach (ar_log[i]) begin
        if (ar_log[i][47:40] == 8'(b)) begin
          exp_len = (k < beats / BURST) ? 8'(BURST - 1) : 8'(beats % BURST - 1);
          if (ar_log[i][39:32] !== exp_len) report_mismatch("arlen", ar_log[i][39:32], exp_len);
          if (ar_log[i][31:0] !== addr + 32'(k * BURST * BEAT_BYTES))
            report_mismatch("araddr", ar_log[i][31:0], addr + 32'(k * BURST * BEAT_BYTES));
          k++;
        end
      end
      if (k != (beats + BURST - 1) / BURST)
        report_mismatch("ar_count", k, (beats + BURST - 1) / BURST);
    end
  endtask

  task automatic run_transfer(input dma_addr_t addr, input int len);
    int n0;
    clear_capture();
    n0 = done_cnt;
    issue_request(addr, len);
    wait_done(n0);
    repeat (2) @(posedge aclk);
    #2;
    if (busy !== 1'b0) report_failure("busy still set after done");
    if (done_cnt != n0 + 1) report_mismatch("done_count", done_cnt, n0 + 1);
    check_stream(addr, len);
    check_bursts(addr, len);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic minimal_request();
    run_transfer(32'h0000_0100, LEN_MIN);
  endtask

  // Two full bursts and three beats per bank
  task automatic burst_split();
    run_transfer(32'h0000_1000, LEN_SPLIT);
  endtask

  task automatic stalled_long_run();
    rand_ready = 1'b1;
    run_transfer(32'h0000_2000, LEN_LONG);
    rand_ready = 1'b0;
  endtask

  task automatic bad_length_reject();
    int e0;
    clear_capture();
    e0 = err_cnt;
    issue_request(32'h0000_0200, 0);
    issue_request(32'h0000_0200, LEN_MIN + BEAT_BYTES);
    repeat (6) @(posedge aclk);
    #2;
    if (err_cnt != e0 + 2) report_mismatch("req_err_count", err_cnt, e0 + 2);
    if (ar_log.size() != 0) report_failure("AR issued for a rejected request");
    if (out_data.size() != 0) report_failure("output beats for a rejected request");
    if (busy !== 1'b0) report_failure("busy set by a rejected request");
  endtask

  // Second request lands while the first holds busy
  task automatic busy_reject();
    int e0;
    int n0;
    clear_capture();
    e0 = err_cnt;
    n0 = done_cnt;
    issue_request(32'h0000_4000, LEN_BUSY);
    issue_request(32'h0000_8000, LEN_MIN);
    wait_done(n0);
    @(posedge aclk);
    #2;
    if (err_cnt != e0 + 1) report_mismatch("req_err_count", err_cnt, e0 + 1);
    check_stream(32'h0000_4000, LEN_BUSY);
    check_bursts(32'h0000_4000, LEN_BUSY);
    run_transfer(32'h0000_6000, LEN_AFTER);
  endtask

  initial begin
    void'($urandom(32'h37c5d6f2));
    aresetn    = 1'b0;
    req_valid  = 1'b0;
    req_addr   = '0;
    req_len    = '0;
    rand_ready = 1'b0;
    repeat (4) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    if (arvalid !== '0 || m_axis_tvalid !== 1'b0 || busy !== 1'b0 ||
        req_err !== 1'b0 || done !== 1'b0)
      report_failure("outputs not idle after reset");
    minimal_request();
    burst_split();
    stalled_long_run();
    bad_length_reject();
    busy_reject();
    repeat (4) @(posedge aclk);
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
